/* vlog.f */
src/audio_pkg.sv
src/wav_pkg.sv
src/sample_fetch.sv
src/wav_header_decode.sv
src/sample_expand.sv
src/i2s_serializer.sv
src/wav_i2s_player.sv
tests/wav_i2s_player_asserts.sv
tests/tb_wav_i2s_player.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_wav_i2s_player
FILELIST = vlog.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_wav_i2s_player.sv */
/*
 * Testbench for the WAV to I2S player
 * Memory model with random ack delay, I2S clock source, slot capture and
 * comparison against a reference expansion of the stored file image
 */
module tb_wav_i2s_player;
	import audio_pkg::*;
	import wav_pkg::*;

	logic clk50 = 1'b0;
	logic reset = 1'b1;
	logic player_enable = 1'b0;
	logic i2s_sclk = 1'b0;
	logic i2s_lrclk = 1'b0;
	logic mem_ack = 1'b0;
	mem_word_t mem_rddata = '0;
	mem_addr_t mem_addr;
	logic mem_rden;
	logic i2s_din;
	fmt_e fmt;

	mem_word_t mem [0:1023];	// File image, one entry per word address
	logic [31:0] lcg_state = 32'd17181;
	int ack_wait = 0;
	int fall_cnt = 0;	// SCLK falls since the last LRCLK edge
	logic [31:0] slot_bits;
	logic slot_live = 1'b0;	// Current slot belongs to playback
	sample_t exp_q[$];	// Expected samples in play order
	sample_t last_sample = '0;
	logic skip_repeats = 1'b0;	// Underrun repeats allowed
	int slots_checked = 0;
	string test_name = "reset";

	wav_i2s_player wav_i2s_player_inst (
		.clk50(clk50), .reset(reset), .player_enable(player_enable),
		.mem_addr(mem_addr), .mem_rden(mem_rden),
		.mem_rddata(mem_rddata), .mem_ack(mem_ack),
		.i2s_sclk(i2s_sclk), .i2s_lrclk(i2s_lrclk),
		.i2s_din(i2s_din), .fmt(fmt)
	);

	bind wav_i2s_player wav_i2s_player_asserts wav_i2s_player_asserts_inst (
		.clk50(clk50), .reset(reset), .mem_rden(mem_rden), .mem_ack(mem_ack),
		.skip_byte(skip_byte), .take_byte(take_byte), .take_word(take_word),
		.i2s_din(i2s_din), .fmt(fmt)
	);

	always #20 clk50 = ~clk50;	// Period 40

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// Expected sample for a stored code by the PCM and G.711 rules
	function automatic sample_t ref_sample(input fmt_e f, input logic [15:0] code);
		logic [7:0] b;
		int e;
		int m;
		int mag;
		sample_t res;
		res = '0;
		case (f)
			FMT_PCM: res = sample_t'(code);
			FMT_ULAW: begin
				b   = ~code[7:0];
				e   = int'(b[6:4]);
				m   = int'(b[3:0]);
				mag = (((2 * m + 33) << e) - 33) * 4;
				res = b[7] ? sample_t'(-mag) : sample_t'(mag);	// Inverted sign set is negative
			end
			FMT_ALAW: begin
				b   = code[7:0] ^ 8'h55;
				e   = int'(b[6:4]);
				m   = int'(b[3:0]);
				mag = (e == 0) ? 2 * m + 1 : (2 * m + 33) << (e - 1);
				mag = mag * 8;
				res = b[7] ? sample_t'(mag) : sample_t'(-mag);
			end
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (exp !== act)
			report_failure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_pad(input string name, input bit exp, input bit act);
		if (exp !== act)
			report_failure($sformatf("FAILED %s pad bit expected %b actual %b", name, exp, act));
	endtask

	task automatic check_fmt(input string name, input fmt_e exp, input fmt_e act);
		if (exp !== act)
			report_failure($sformatf("FAILED %s expected %s actual %s", name, exp.name(),
				act.name()));
	endtask

	task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
		if (exp !== act)
			report_failure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
	endtask

	// Memory model acks each read 2 to 4 cycles after the request
	always @(negedge clk50) begin
		if (reset) begin
			mem_ack  = 1'b0;
			ack_wait = 0;
		end else if (mem_ack) begin
			mem_ack = 1'b0;
		end else if (mem_rden) begin
			if (ack_wait == 0)
				ack_wait = 2 + int'(lcg_next() % 16'd3);
			else if (ack_wait == 1) begin
				mem_rddata = mem[mem_addr[9:0]];
				mem_ack    = 1'b1;
				ack_wait   = 0;
			end else
				ack_wait--;
		end
	end

	// Codec side clocks with 16 clk50 per SCLK and 32 SCLK per LRCLK phase
	always begin
		repeat (8) @(negedge clk50);
		i2s_sclk = 1'b1;
		repeat (8) @(negedge clk50);
		i2s_sclk = 1'b0;
		if (fall_cnt == 31) begin
			fall_cnt  = 0;
			i2s_lrclk = ~i2s_lrclk;	// Channel change on the SCLK fall
		end else
			fall_cnt++;
	end

	task automatic compare_slot();
		sample_t got;
		got = sample_t'(slot_bits[31:16]);
		if (skip_repeats && got == last_sample)
			return;	// Underrun slot
		if (exp_q.size() == 0)
			report_failure("Played slot arrived with no expected sample left");
		check_sample(test_name, exp_q[0], got);
		for (int k = 15; k >= 0; k--)
			check_pad(test_name, exp_q[0][15], slot_bits[k]);
		void'(exp_q.pop_front());
		last_sample = got;
		slots_checked++;
	endtask

	// Bit k of a slot is seen at the rise after fall k
	always @(posedge i2s_sclk) begin
		if (reset) begin
			slot_live = 1'b0;
		end else if (fall_cnt == 0) begin
			slot_bits[0] = i2s_din;
			if (slot_live)
				compare_slot();
		end else begin
			if (fall_cnt == 1)
				slot_live = wav_i2s_player_inst.i2s_serializer_inst.armed;
			slot_bits[32-fall_cnt] = i2s_din;
		end
	end

	// Builds the image, resets the DUT and queues the expected samples
	task automatic load_image(input logic [15:0] tag_lo, input logic [15:0] code, input fmt_e f);
		logic [15:0] w;
		@(negedge clk50);
		reset         = 1'b1;
		player_enable = 1'b1;
		exp_q.delete();
		skip_repeats  = 1'b0;
		slots_checked = 0;
		for (int i = 0; i < 1024; i++)
			mem[i] = lcg_next();
		mem[0]  = 16'h4952;	// "RI"
		mem[1]  = tag_lo;
		mem[10] = code;	// Format code at byte 20
		for (int i = 0; i < 64; i++) begin
			w = mem[22 + (f == FMT_PCM ? i : i / 2)];
			if (f == FMT_PCM)
				exp_q.push_back(ref_sample(f, w));
			else
				exp_q.push_back(ref_sample(f, (i % 2 == 0) ? {8'h00, w[15:8]} : {8'h00, w[7:0]}));
		end
		repeat (10) @(negedge clk50);
		reset = 1'b0;
	endtask

	task automatic wait_slots(input int n);
		int t;
		t = 0;
		while (slots_checked < n) begin
			@(negedge clk50);
			t++;
			if (t > 40000)
				report_failure($sformatf("%s timed out waiting for played slots", test_name));
		end
	endtask

	task automatic wait_fmt(input fmt_e f);
		int t;
		t = 0;
		while (fmt != f && t < 5000) begin
			@(negedge clk50);
			t++;
		end
		check_fmt(test_name, f, fmt);
	endtask

	// Waits until the reader has stopped for good
	task automatic wait_fetch_idle();
		int t;
		int stable;
		mem_addr_t prev;
		t      = 0;
		stable = 0;
		prev   = mem_addr;
		while (stable < 200) begin
			@(negedge clk50);
			stable = (mem_addr == prev && !mem_rden) ? stable + 1 : 0;
			prev   = mem_addr;
			t++;
			if (t > 10000)
				report_failure($sformatf("%s memory reads never stopped", test_name));
		end
	endtask

	// Lets a read already on the bus get its ack
	task automatic wait_read_done();
		int t;
		t = 0;
		while (mem_rden) begin
			@(negedge clk50);
			t++;
			if (t > 100)
				report_failure($sformatf("%s open memory read never completed", test_name));
		end
	endtask

	task automatic expect_silence();
		repeat (4 * 2 * 32 * 16) begin	// Four stereo frames
			@(negedge clk50);
			if (i2s_din !== 1'b0)
				report_failure($sformatf("%s data line went high on an unplayable file",
					test_name));
		end
	endtask

	initial begin
		mem_addr_t held;
		int base;
		repeat (5) @(negedge clk50);
		check_pad("reset din", 1'b0, i2s_din);
		check_pad("reset rden", 1'b0, mem_rden);
		check_addr("reset addr", '0, mem_addr);
		check_fmt("reset fmt", FMT_NONE, fmt);

		test_name = "pcm";
		load_image(16'h4646, FMT_CODE_PCM, FMT_PCM);
		wait_fmt(FMT_PCM);
		wait_slots(16);

		test_name = "alaw";
		load_image(16'h4646, FMT_CODE_ALAW, FMT_ALAW);
		wait_fmt(FMT_ALAW);
		wait_slots(16);

		test_name = "ulaw";
		load_image(16'h4646, FMT_CODE_ULAW, FMT_ULAW);
		wait_fmt(FMT_ULAW);
		wait_slots(16);

		test_name = "bad tag";
		load_image(16'h4647, FMT_CODE_PCM, FMT_PCM);
		wait_fetch_idle();
		check_fmt(test_name, FMT_NONE, fmt);
		expect_silence();

		test_name = "bad code";
		load_image(16'h4646, 16'h0003, FMT_PCM);
		wait_fetch_idle();
		check_fmt(test_name, FMT_NONE, fmt);
		expect_silence();

		test_name = "pause";
		load_image(16'h4646, FMT_CODE_PCM, FMT_PCM);
		wait_slots(4);
		@(negedge clk50);
		player_enable = 1'b0;
		skip_repeats  = 1'b1;
		wait_read_done();
		held = mem_addr;
		repeat (2048) @(negedge clk50);
		check_addr(test_name, held, mem_addr);
		player_enable = 1'b1;
		base = slots_checked;
		wait_slots(base + 6);

		$display("All tests passed!");
		$finish;
	end

endmodule

/* tests/wav_i2s_player_asserts.sv */
/*
 * Bus and queue handshake properties of the player
 */
module wav_i2s_player_asserts (
	input logic            clk50,
	input logic            reset,
	input logic            mem_rden,
	input logic            mem_ack,
	input logic            skip_byte,
	input logic            take_byte,
	input logic            take_word,
	input logic            i2s_din,
	input audio_pkg::fmt_e fmt
);
	import audio_pkg::*;

	// Read request stays up until acknowledged
	rden_held: assert property (@(posedge clk50) disable iff (reset)
		mem_rden && !mem_ack |=> mem_rden)
		else $error("mem_rden dropped before mem_ack");

	// One consumer at a time
	one_consumer: assert property (@(posedge clk50) disable iff (reset)
		$onehot0({skip_byte, take_byte, take_word}))
		else $error("several queue consume pulses in one cycle");

	silent_none: assert property (@(posedge clk50) disable iff (reset)
		fmt == FMT_NONE |-> !i2s_din)	// Unsupported file plays silence
		else $error("i2s_din high while fmt is FMT_NONE");

endmodule

/* src/wav_i2s_player.sv */
/*
 * WAV to I2S player top level
 * Reads a WAV image over the memory bus and plays it to a slave mode codec
 */
module wav_i2s_player (
	input  logic               clk50,
	input  logic               reset,
	input  logic               player_enable,
	output wav_pkg::mem_addr_t mem_addr,
	output logic               mem_rden,
	input  wav_pkg::mem_word_t mem_rddata,
	input  logic               mem_ack,
	input  logic               i2s_sclk,
	input  logic               i2s_lrclk,
	output logic               i2s_din,
	output audio_pkg::fmt_e    fmt
);
	import audio_pkg::*;
	import wav_pkg::*;

	logic q_ready;
	logic skip_byte, take_byte, take_word;	// Queue consume pulses
	logic play_enable;
	logic sample_req;
	logic [QUEUE_BITS-SAMPLE_BITS-1:0] queue_head;	// Tag lookahead needs two words
	sample_t sample;

	sample_fetch sample_fetch_inst (
		.clk50(clk50), .reset(reset), .player_enable(player_enable),
		.skip_byte(skip_byte), .take_byte(take_byte), .take_word(take_word),
		.mem_rddata(mem_rddata), .mem_ack(mem_ack),
		.mem_addr(mem_addr), .mem_rden(mem_rden),
		.q_ready(q_ready), .queue_head(queue_head)
	);

	wav_header_decode wav_header_decode_inst (
		.clk50(clk50), .reset(reset), .player_enable(player_enable),
		.q_ready(q_ready), .queue_head(queue_head),
		.skip_byte(skip_byte), .fmt(fmt), .play_enable(play_enable)
	);

	sample_expand sample_expand_inst (
		.clk50(clk50), .reset(reset), .fmt(fmt),
		.sample_req(sample_req), .q_ready(q_ready), .queue_head(queue_head),
		.sample(sample), .take_byte(take_byte), .take_word(take_word)
	);

	i2s_serializer i2s_serializer_inst (
		.clk50(clk50), .reset(reset), .play_enable(play_enable),
		.i2s_sclk(i2s_sclk), .i2s_lrclk(i2s_lrclk), .sample(sample),
		.sample_req(sample_req), .i2s_din(i2s_din)
	);

endmodule

/* src/i2s_serializer.sv */
/*
 * I2S slave transmitter
 * Brings the codec's SCLK and LRCLK into clk50, asks for a sample at each
 * channel start and shifts it out MSB first with sign padding
 */
module i2s_serializer (
	input  logic               clk50,
	input  logic               reset,
	input  logic               play_enable,
	input  logic               i2s_sclk,
	input  logic               i2s_lrclk,
	input  audio_pkg::sample_t sample,
	output logic               sample_req,
	output logic               i2s_din
);
	import audio_pkg::*;

	logic [1:0] sclk_sync, lrclk_sync;	// Two flop synchronizers
	logic sclk_prev, lrclk_prev;
	logic sclk_fall, lrclk_edge, lrclk_fall;
	logic armed;	// Playing, frames start on a left channel
	logic arm_now;
	logic [5:0] slot_cnt;	// SCLK falls since the last LRCLK edge
	logic [3:0] bit_idx;

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			sclk_sync  <= 2'b00;
			lrclk_sync <= 2'b00;
			sclk_prev  <= 1'b0;
			lrclk_prev <= 1'b0;
		end else begin
			sclk_sync  <= {sclk_sync[0], i2s_sclk};
			lrclk_sync <= {lrclk_sync[0], i2s_lrclk};
			sclk_prev  <= sclk_sync[1];
			lrclk_prev <= lrclk_sync[1];
		end
	end

	assign sclk_fall  = sclk_prev && !sclk_sync[1];
	assign lrclk_edge = lrclk_prev != lrclk_sync[1];
	assign lrclk_fall = lrclk_prev && !lrclk_sync[1];	// Start of a left channel

	// First left channel after the header is done
	assign arm_now = play_enable && lrclk_fall;

	// Fall k drives bit 16 - k, counter holds k - 1
	assign bit_idx = 4'(SAMPLE_BITS - 1) - slot_cnt[3:0];

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			armed      <= 1'b0;
			sample_req <= 1'b0;
			slot_cnt   <= 6'd0;
		end else begin
			if (arm_now)
				armed <= 1'b1;
			sample_req <= lrclk_edge && (armed || arm_now);	// One cycle behind the edge
			if (lrclk_edge)
				slot_cnt <= 6'd0;	// A fall together with the edge is not counted
			else if (sclk_fall && (slot_cnt != 6'(SLOT_BITS)))
				slot_cnt <= slot_cnt + 6'd1;
		end
	end

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			i2s_din <= 1'b0;
		end else if (!armed) begin
			i2s_din <= 1'b0;	// Silence until playback starts
		end else if (sclk_fall && !lrclk_edge) begin
			if (slot_cnt < 6'(SAMPLE_BITS))
				i2s_din <= sample[bit_idx];
			else
				i2s_din <= sample[SAMPLE_BITS-1];	// Sign into the unused slot bits
		end
	end

endmodule

/* src/sample_expand.sv */
/*
 * Sample expander
 * On request turns the queue head into a 16 bit sample, PCM word or
 * G.711 A-law / µ-law byte, and consumes what it used
 */
module sample_expand (
	input  logic              clk50,
	input  logic              reset,
	input  audio_pkg::fmt_e   fmt,
	input  logic              sample_req,
	input  logic              q_ready,
	input  logic [31:0]       queue_head,
	output audio_pkg::sample_t sample,
	output logic              take_byte,
	output logic              take_word
);
	import audio_pkg::*;

	logic [7:0] ulaw_byte, alaw_byte;
	logic [2:0] ulaw_exp, alaw_exp;
	logic [3:0] ulaw_man, alaw_man;
	logic [15:0] ulaw_base, ulaw_mag;
	logic [15:0] alaw_base, alaw_mag;
	sample_t pcm_val, ulaw_val, alaw_val;

	// Little endian word, already in order at the head
	assign pcm_val = sample_t'(queue_head[31:16]);

	// µ-law, stored inverted
	assign ulaw_byte = ~queue_head[31:24];
	assign ulaw_exp  = ulaw_byte[6:4];
	assign ulaw_man  = ulaw_byte[3:0];
	assign ulaw_base = {11'd0, ulaw_man, 1'b0} + ULAW_BIAS;	// 2m + 33
	assign ulaw_mag  = (ulaw_base << ulaw_exp) - ULAW_BIAS;
	assign ulaw_val  = ulaw_byte[7] ? -sample_t'(ulaw_mag << 2)	// 14 bit range up to 16
		: sample_t'(ulaw_mag << 2);

	// A-law, even bits flipped, set sign bit means positive
	assign alaw_byte = queue_head[31:24] ^ ALAW_XOR;
	assign alaw_exp  = alaw_byte[6:4];
	assign alaw_man  = alaw_byte[3:0];
	assign alaw_base = {11'd0, alaw_man, 1'b1} +
		((alaw_exp == 3'd0) ? 16'd0 : 16'd32);	// Segment leading one above segment 0
	assign alaw_mag  = (alaw_exp == 3'd0) ? alaw_base : alaw_base << (alaw_exp - 3'd1);
	assign alaw_val  = alaw_byte[7] ? sample_t'(alaw_mag << 3)	// 13 bit range up to 16
		: -sample_t'(alaw_mag << 3);

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			sample    <= '0;
			take_byte <= 1'b0;
			take_word <= 1'b0;
		end else begin
			take_byte <= 1'b0;
			take_word <= 1'b0;
			// Underrun keeps the last sample and leaves the queue alone
			if (sample_req && q_ready) begin
				case (fmt)
					FMT_PCM: begin
						sample    <= pcm_val;
						take_word <= 1'b1;
					end
					FMT_ALAW: begin
						sample    <= alaw_val;
						take_byte <= 1'b1;
					end
					FMT_ULAW: begin
						sample    <= ulaw_val;
						take_byte <= 1'b1;
					end
					default: sample <= '0;	// Nothing to decode
				endcase
			end
		end
	end

endmodule

/* src/wav_header_decode.sv */
/*
 * WAV header walker
 * Checks the RIFF tag, skips to the format code, classifies it
 * and skips on to the first sample byte
 */
module wav_header_decode (
	input  logic             clk50,
	input  logic             reset,
	input  logic             player_enable,
	input  logic             q_ready,
	input  logic [31:0]      queue_head,
	output logic             skip_byte,
	output audio_pkg::fmt_e  fmt,
	output logic             play_enable
);
	import audio_pkg::*;
	import wav_pkg::*;

	hdr_state_e state, state_next;
	fmt_e fmt_next;
	logic [4:0] skip_cnt, skip_cnt_next;	// Bytes skipped in the current skip state
	logic [4:0] skip_last;
	logic [15:0] fmt_code;
	logic advance;

	assign advance     = q_ready && player_enable;	// One step per cycle with a valid head
	assign fmt_code    = queue_head[31:16];
	assign play_enable = (state == H_PLAY);

	assign skip_last = (state == H_SKIP_FMT) ? 5'(SKIP_TO_FMT_BYTES - 1)
		: 5'(SKIP_TO_DATA_BYTES - 1);

	always_comb begin
		state_next    = state;
		fmt_next      = fmt;
		skip_cnt_next = skip_cnt;
		skip_byte     = 1'b0;
		if (advance) begin
			case (state)
				H_CHECK_RIFF: begin
					if (queue_head == RIFF_TAG)
						state_next = H_SKIP_FMT;
					else
						state_next = H_STOP;	// Not a RIFF file
				end
				H_SKIP_FMT, H_SKIP_DATA: begin
					skip_byte     = 1'b1;
					skip_cnt_next = skip_cnt + 5'd1;
					if (skip_cnt == skip_last) begin
						skip_cnt_next = 5'd0;
						state_next    = (state == H_SKIP_FMT) ? H_CLASSIFY : H_PLAY;
					end
				end
				H_CLASSIFY: begin
					state_next = H_SKIP_DATA;
					case (fmt_code)
						FMT_CODE_PCM:  fmt_next = FMT_PCM;
						FMT_CODE_ALAW: fmt_next = FMT_ALAW;
						FMT_CODE_ULAW: fmt_next = FMT_ULAW;
						default: begin
							fmt_next   = FMT_NONE;	// Unsupported coding
							state_next = H_STOP;
						end
					endcase
				end
				default: ;	// H_PLAY and H_STOP hold
			endcase
		end
	end

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			state    <= H_CHECK_RIFF;
			fmt      <= FMT_NONE;
			skip_cnt <= 5'd0;
		end else begin
			state    <= state_next;
			fmt      <= fmt_next;
			skip_cnt <= skip_cnt_next;
		end
	end

endmodule

/* src/sample_fetch.sv */
/*
 * Memory reader feeding a 48 bit queue
 * Loads three words from address zero, shifts by bytes or words on request
 * and refills the vacated low word from the next address
 */
module sample_fetch (
	input  logic               clk50,
	input  logic               reset,
	input  logic               player_enable,
	input  logic               skip_byte,
	input  logic               take_byte,
	input  logic               take_word,
	input  wav_pkg::mem_word_t mem_rddata,
	input  logic               mem_ack,
	output wav_pkg::mem_addr_t mem_addr,
	output logic               mem_rden,
	output logic               q_ready,
	output logic [31:0]        queue_head
);
	import audio_pkg::*;
	import wav_pkg::*;

	logic [QUEUE_BITS-1:0] queue;
	logic [QUEUE_BITS-1:0] queue_shifted;
	logic [5:0] consumed;	// Bits shifted out since the last refill
	logic [5:0] cons_sum;
	logic [5:0] shift_amt;
	logic [1:0] fill_cnt;	// Words loaded after reset, 3 when full
	logic filling;
	logic capture;
	logic refill;
	logic need_word;

	assign filling   = (fill_cnt != 2'd3);
	assign capture   = mem_rden && mem_ack;	// Data valid this cycle
	assign refill    = capture && !filling;
	assign need_word = filling || (consumed >= 6'(SAMPLE_BITS));

	// Consumers never pulse together
	always_comb begin
		if (skip_byte || take_byte)
			shift_amt = 6'd8;
		else if (take_word)
			shift_amt = 6'd16;
		else
			shift_amt = 6'd0;
	end

	assign cons_sum      = consumed + shift_amt;
	assign queue_shifted = queue << shift_amt;

	always_ff @(posedge clk50) begin
		if (capture && filling)
			queue[(2 - fill_cnt) * SAMPLE_BITS +: SAMPLE_BITS] <= mem_rddata;	// Top third first
		else if (refill)	// New word goes right under the valid bits
			queue <= queue_shifted |
				(QUEUE_BITS'(mem_rddata) << (cons_sum - 6'(SAMPLE_BITS)));
		else
			queue <= queue_shifted;
	end

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			mem_rden <= 1'b0;
			mem_addr <= '0;
			fill_cnt <= 2'd0;
			consumed <= 6'd0;
		end else begin
			if (capture) begin
				mem_rden <= 1'b0;	// Drop for one cycle after the ack
				mem_addr <= mem_addr + 1'b1;
				if (filling)
					fill_cnt <= fill_cnt + 2'd1;
			end else if (player_enable && !mem_rden && need_word) begin
				mem_rden <= 1'b1;	// Address already stable
			end
			// A pulse issued under q_ready is always honoured
			consumed <= refill ? cons_sum - 6'(SAMPLE_BITS) : cons_sum;
		end
	end

	// Ready only with a full queue and less than a word gone
	assign q_ready    = player_enable && !filling && (consumed < 6'(SAMPLE_BITS));
	assign queue_head = queue[QUEUE_BITS-1 -: 32];

endmodule

/* src/wav_pkg.sv */
/*
 * WAV file and memory bus definitions
 * Tag and format codes as seen at the queue head, header skip lengths and bus widths
 */
package wav_pkg;

	// Memory bus, one address per 16 bit word
	typedef logic [24:0] mem_addr_t;
	typedef logic [15:0] mem_word_t;

	// "RIFF" as it lands in the queue, bytes swapped inside each word
	localparam logic [31:0] RIFF_TAG = 32'h49524646;

	// Audio format field of the fmt chunk
	localparam logic [15:0] FMT_CODE_PCM  = 16'h0001;
	localparam logic [15:0] FMT_CODE_ALAW = 16'h0006;
	localparam logic [15:0] FMT_CODE_ULAW = 16'h0007;

	localparam int SKIP_TO_FMT_BYTES  = 20;	// Byte 0 to the format code at byte 20
	localparam int SKIP_TO_DATA_BYTES = 24;	// Byte 20 to the first sample at byte 44

	localparam int QUEUE_BITS = 48;	// Three memory words

	typedef enum logic [2:0] {
		H_CHECK_RIFF,
		H_SKIP_FMT,
		H_CLASSIFY,
		H_SKIP_DATA,
		H_PLAY,
		H_STOP	// Bad tag or unsupported code, stays here
	} hdr_state_e;

endpackage

/* src/audio_pkg.sv */
/*
 * Audio side definitions shared by the player
 * Sample and slot widths, G.711 expansion constants and the playback format
 */
package audio_pkg;

	// I2S frame shape
	localparam int SAMPLE_BITS = 16;	// Data bits per channel slot
	localparam int SLOT_BITS   = 32;	// SCLK periods per channel

	// G.711 expansion
	localparam logic [7:0]  ALAW_XOR  = 8'h55;	// A-law flips the even bits
	localparam logic [15:0] ULAW_BIAS = 16'd33;	// µ-law bias added before the segment shift

	// Two's-complement sample as it goes out on the data line
	typedef logic signed [SAMPLE_BITS-1:0] sample_t;

	// Playback format found in the header
	typedef enum logic [1:0] {
		FMT_NONE = 2'd0,	// Unsupported or not yet known, plays silence
		FMT_PCM  = 2'd1,	// 16 bit linear
		FMT_ALAW = 2'd2,
		FMT_ULAW = 2'd3
	} fmt_e;

endpackage
